// File: src/cpu_cfg_pkg.sv
package cpu_cfg_pkg;

	// base sizing
	localparam int unsigned XLEN        = 32;  // address and instruction width
	localparam int unsigned FETCH_WIDTH = 4;   // words per block, queue channels (power of two)
	localparam int unsigned IQ_DEPTH    = 8;   // entries per queue channel
	localparam int unsigned RESP_DEPTH  = 2;   // response buffer, also caps requests in flight

	// derived widths
	localparam int unsigned IDX_W       = $clog2(FETCH_WIDTH);      // word index within a block
	localparam int unsigned CNT_W       = $clog2(FETCH_WIDTH + 1);  // push and pop counts
	localparam int unsigned RESP_CNT_W  = $clog2(RESP_DEPTH + 1);   // credit counters

	// byte addressing of words and blocks
	localparam int unsigned INSTR_BYTES = XLEN / 8;
	localparam int unsigned BYTE_OFF_W  = $clog2(INSTR_BYTES);
	localparam int unsigned BLK_LSB     = IDX_W + BYTE_OFF_W;  // first bit above the block offset
	localparam int unsigned BLK_BYTES   = FETCH_WIDTH * INSTR_BYTES;

endpackage

// File: src/fetch_pkg.sv
package fetch_pkg;

	import cpu_cfg_pkg::*;

	// request to instruction memory, addr is block aligned
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] addr;
	} fetch_req_t;

	// one block back from memory, word 0 at the lowest address
	typedef struct packed {
		logic                             valid;
		logic [FETCH_WIDTH-1:0][XLEN-1:0] data;
	} fetch_resp_t;

	// instruction queue entry
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] instr;
	} instr_entry_t;

	// redirect from the back end
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;  // new fetch pc, word aligned
	} redirect_t;

endpackage

// File: src/fifo_v3.sv
`timescale 1ns/1ps

module fifo_v3 #(
	parameter int unsigned DEPTH = 8,
	parameter type         dtype = logic [31:0]
)(
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         flush_i,  // drops all entries
	input  logic                         push_i,
	input  logic                         pop_i,
	input  dtype                         data_i,
	output logic                         full_o,
	output logic                         empty_o,
	output logic [$clog2(DEPTH+1)-1:0]   usage_o,
	output dtype                         data_o    // head entry
);

	localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(DEPTH + 1);

	dtype             mem_q [DEPTH];
	logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
	logic [CNT_W-1:0] cnt_q;
	logic             do_push, do_pop;

	// wraps at DEPTH, so any depth works
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full_o  = (cnt_q == CNT_W'(DEPTH));
	assign empty_o = (cnt_q == '0);
	assign usage_o = cnt_q;
	assign data_o  = mem_q[rd_ptr_q];

	assign do_push = push_i & ~full_o;   // push into a full fifo is ignored
	assign do_pop  = pop_i & ~empty_o;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			cnt_q    <= '0;
		end else if (flush_i) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			cnt_q    <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= next_ptr(wr_ptr_q);
			if (do_pop)
				rd_ptr_q <= next_ptr(rd_ptr_q);
			cnt_q <= cnt_q + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_push && !flush_i)
			mem_q[wr_ptr_q] <= data_i;
	end

endmodule

// File: src/multi_queue.sv
`timescale 1ns/1ps

module multi_queue
	import cpu_cfg_pkg::*;
#(
	parameter int unsigned DEPTH   = IQ_DEPTH,     // per channel
	parameter int unsigned CHANNEL = FETCH_WIDTH,  // power of two
	parameter type         dtype   = logic [XLEN-1:0]
)(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          flush_i,
	input  dtype [CHANNEL-1:0]            data_push_i,
	input  logic [$clog2(CHANNEL+1)-1:0]  push_num_i,
	input  logic [$clog2(CHANNEL)-1:0]    push_offset_i,  // first valid slot of data_push_i
	input  logic [$clog2(CHANNEL+1)-1:0]  pop_num_i,
	output logic                          full_o,         // any channel full
	output logic                          empty_o,        // every channel empty
	output dtype [CHANNEL-1:0]            data_pop_o,     // slot 0 is the oldest
	output logic [CHANNEL-1:0]            pop_valid_o
);

	typedef logic [$clog2(CHANNEL)-1:0] index_t;

	logic [CHANNEL-1:0] ch_push, ch_pop;
	logic [CHANNEL-1:0] ch_full, ch_empty;
	dtype [CHANNEL-1:0] ch_din, ch_dout;

	index_t rd_ptr_q, wr_ptr_q;  // channel holding the oldest entry / next free slot
	index_t [CHANNEL-1:0] rd_sel;  // channel seen at output i
	index_t [CHANNEL-1:0] rd_rel, wr_rel;  // age of channel i relative to the pointers

	assign full_o  = |ch_full;
	assign empty_o = &ch_empty;

	for (genvar i = 0; i < CHANNEL; i++) begin : gen_idx
		assign rd_sel[i] = rd_ptr_q + index_t'(i);
		assign rd_rel[i] = index_t'(i) - rd_ptr_q;
		assign wr_rel[i] = index_t'(i) - wr_ptr_q;
	end

	// rotate channel heads so output 0 is the oldest
	for (genvar i = 0; i < CHANNEL; i++) begin : gen_out
		assign data_pop_o[i]  = ch_dout[rd_sel[i]];
		assign pop_valid_o[i] = ~ch_empty[rd_sel[i]];
	end

	// entry k of a push goes to channel wr_ptr + k
	for (genvar i = 0; i < CHANNEL; i++) begin : gen_req
		assign ch_din[i]  = data_push_i[push_offset_i + wr_rel[i]];
		assign ch_push[i] = (wr_rel[i] < push_num_i);
		assign ch_pop[i]  = (rd_rel[i] < pop_num_i);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
		end else if (flush_i) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
		end else begin
			rd_ptr_q <= rd_ptr_q + index_t'(pop_num_i);   // a count of CHANNEL wraps to itself
			wr_ptr_q <= wr_ptr_q + index_t'(push_num_i);
		end
	end

	for (genvar i = 0; i < CHANNEL; i++) begin : gen_fifo
		fifo_v3 #(
			.DEPTH   ( DEPTH ),
			.dtype   ( dtype )
		) u_fifo (
			.clk     ( clk         ),
			.rst_n   ( rst_n       ),
			.flush_i ( flush_i     ),
			.push_i  ( ch_push[i]  ),
			.pop_i   ( ch_pop[i]   ),
			.data_i  ( ch_din[i]   ),
			.full_o  ( ch_full[i]  ),
			.empty_o ( ch_empty[i] ),
			.usage_o (             ),
			.data_o  ( ch_dout[i]  )
		);
	end

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
	import cpu_cfg_pkg::*;
	import fetch_pkg::*;
(
	input  logic                            clk,
	input  logic                            rst_n,
	input  redirect_t                       redirect_i,
	input  fetch_resp_t                     imem_resp_i,
	input  logic                            iq_full_i,
	output fetch_req_t                      imem_req_o,
	output logic                            iq_flush_o,
	output instr_entry_t [FETCH_WIDTH-1:0]  iq_push_data_o,
	output logic [CNT_W-1:0]                iq_push_num_o,
	output logic [IDX_W-1:0]                iq_push_offset_o
);

	// buffered block, tagged with its address
	typedef struct packed {
		logic [XLEN-1:0]                  addr;
		logic [FETCH_WIDTH-1:0][XLEN-1:0] words;
	} resp_entry_t;

	logic                  run_q;         // low for the reset cycle
	logic [XLEN-1:0]       req_addr_q;    // next block to request
	logic [XLEN-1:0]       resp_addr_q;   // block of the next kept response
	logic [XLEN-1:0]       push_pc_q;     // next pc to push into the queue
	logic [RESP_CNT_W-1:0] inflight_q;    // requests not yet answered
	logic [RESP_CNT_W-1:0] discard_q;     // of those, answers to drop
	logic [RESP_CNT_W-1:0] buf_usage;
	logic [RESP_CNT_W:0]   credit_used;
	logic                  redirect;
	logic                  req_fire, resp_arrive, resp_keep, push_fire;
	logic                  buf_empty;
	resp_entry_t           buf_in, buf_head;
	logic [IDX_W-1:0]      push_off;

	function automatic logic [XLEN-1:0] block_of(input logic [XLEN-1:0] pc);
		return {pc[XLEN-1:BLK_LSB], {BLK_LSB{1'b0}}};
	endfunction

	assign redirect = redirect_i.valid;

	// requests in flight and buffered blocks share RESP_DEPTH credits
	assign credit_used = {1'b0, inflight_q} + {1'b0, buf_usage};
	assign req_fire    = run_q & ~redirect & (credit_used < (RESP_CNT_W+1)'(RESP_DEPTH));

	assign resp_arrive = imem_resp_i.valid;
	assign resp_keep   = resp_arrive & ~redirect & (discard_q == '0);  // stale blocks dropped
	assign push_fire   = ~buf_empty & ~iq_full_i & ~redirect;

	assign imem_req_o.valid = req_fire;
	assign imem_req_o.addr  = req_addr_q;

	assign buf_in.addr  = resp_addr_q;
	assign buf_in.words = imem_resp_i.data;

	fifo_v3 #(
		.DEPTH   ( RESP_DEPTH   ),
		.dtype   ( resp_entry_t )
	) u_resp_buf (
		.clk     ( clk         ),
		.rst_n   ( rst_n       ),
		.flush_i ( redirect    ),
		.push_i  ( resp_keep   ),
		.pop_i   ( push_fire   ),
		.data_i  ( buf_in      ),
		.full_o  (             ),
		.empty_o ( buf_empty   ),
		.usage_o ( buf_usage   ),
		.data_o  ( buf_head    )
	);

	// words below the push pc are skipped, nonzero only after a redirect
	assign push_off = push_pc_q[BLK_LSB-1:BYTE_OFF_W];

	always_comb begin
		for (int i = 0; i < FETCH_WIDTH; i++) begin
			iq_push_data_o[i].pc    = buf_head.addr + XLEN'(i * INSTR_BYTES);
			iq_push_data_o[i].instr = buf_head.words[i];
		end
	end

	assign iq_push_num_o    = push_fire ? CNT_W'(FETCH_WIDTH) - CNT_W'(push_off) : '0;
	assign iq_push_offset_o = push_off;
	assign iq_flush_o       = redirect;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_q       <= 1'b0;
			req_addr_q  <= '0;
			resp_addr_q <= '0;
			push_pc_q   <= '0;
			inflight_q  <= '0;
			discard_q   <= '0;
		end else begin
			run_q      <= 1'b1;
			inflight_q <= inflight_q + RESP_CNT_W'(req_fire) - RESP_CNT_W'(resp_arrive);
			if (redirect) begin
				req_addr_q  <= block_of(redirect_i.pc);
				resp_addr_q <= block_of(redirect_i.pc);
				push_pc_q   <= redirect_i.pc;
				// everything still out belongs to the old path
				discard_q   <= inflight_q - RESP_CNT_W'(resp_arrive);
			end else begin
				if (req_fire)
					req_addr_q <= req_addr_q + XLEN'(BLK_BYTES);
				if (resp_keep)
					resp_addr_q <= resp_addr_q + XLEN'(BLK_BYTES);
				if (push_fire)
					push_pc_q <= buf_head.addr + XLEN'(BLK_BYTES);  // next block, offset 0
				if (resp_arrive && discard_q != '0)
					discard_q <= discard_q - 1'b1;
			end
		end
	end

endmodule

// File: src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
	import cpu_cfg_pkg::*;
	import fetch_pkg::*;
(
	input  logic                            clk,
	input  logic                            rst_n,
	input  redirect_t                       redirect_i,
	input  fetch_resp_t                     imem_resp_i,
	input  logic [CNT_W-1:0]                pop_num_i,
	output fetch_req_t                      imem_req_o,
	output instr_entry_t [FETCH_WIDTH-1:0]  instr_o,
	output logic [FETCH_WIDTH-1:0]          instr_valid_o
);

	logic                           iq_flush, iq_full;
	instr_entry_t [FETCH_WIDTH-1:0] iq_push_data;
	logic [CNT_W-1:0]               iq_push_num;
	logic [IDX_W-1:0]               iq_push_offset;

	fetch_unit u_fetch (
		.clk              ( clk            ),
		.rst_n            ( rst_n          ),
		.redirect_i       ( redirect_i     ),
		.imem_resp_i      ( imem_resp_i    ),
		.iq_full_i        ( iq_full        ),
		.imem_req_o       ( imem_req_o     ),
		.iq_flush_o       ( iq_flush       ),
		.iq_push_data_o   ( iq_push_data   ),
		.iq_push_num_o    ( iq_push_num    ),
		.iq_push_offset_o ( iq_push_offset )
	);

	multi_queue #(
		.DEPTH         ( IQ_DEPTH      ),
		.CHANNEL       ( FETCH_WIDTH   ),
		.dtype         ( instr_entry_t )
	) u_iq (
		.clk           ( clk            ),
		.rst_n         ( rst_n          ),
		.flush_i       ( iq_flush       ),
		.data_push_i   ( iq_push_data   ),
		.push_num_i    ( iq_push_num    ),
		.push_offset_i ( iq_push_offset ),
		.pop_num_i     ( pop_num_i      ),
		.full_o        ( iq_full        ),
		.empty_o       (                ),
		.data_pop_o    ( instr_o        ),
		.pop_valid_o   ( instr_valid_o  )
	);

endmodule

// File: sim/fetch_assertions.sv
`timescale 1ns/1ps

module fetch_assertions
	import cpu_cfg_pkg::*;
	import fetch_pkg::*;
(
	input logic                           clk,
	input logic                           rst_n,
	input redirect_t                      redirect_i,
	input fetch_resp_t                    imem_resp_i,
	input logic [CNT_W-1:0]               pop_num_i,
	input logic [CNT_W-1:0]               iq_push_num_i,  // words pushed into the queue
	input fetch_req_t                     imem_req_o,
	input instr_entry_t [FETCH_WIDTH-1:0] instr_o,
	input logic [FETCH_WIDTH-1:0]         instr_valid_o
);

	logic [XLEN-1:0] exp_pc_q;     // pc of the next entry to pop
	logic [3:0]      credit_q;     // blocks requested since the last redirect, not yet pushed
	logic            seen_req_q;
	logic            seen_resp_q;
	logic            pop_live;
	logic            failed;
	int unsigned     bad_idx;      // first popped entry off the expected path
	logic [XLEN-1:0] step_pc;
	logic [XLEN-1:0] want_pc;
	logic [XLEN-1:0] got_pc;
	logic [XLEN-1:0] got_instr;
	logic [5:0]      fired = '0;   // one bit per assertion

	assign pop_live = (pop_num_i != '0) && !redirect_i.valid;  // pops under a flush are lost
	assign failed   = |fired;

	// popped entries continue from exp_pc word by word, each holding its inverted pc
	always_comb begin
		bad_idx   = FETCH_WIDTH;
		step_pc   = exp_pc_q;
		want_pc   = exp_pc_q;
		got_pc    = instr_o[0].pc;
		got_instr = instr_o[0].instr;
		for (int i = 0; i < FETCH_WIDTH; i++) begin
			step_pc = exp_pc_q + XLEN'(i * INSTR_BYTES);
			if (bad_idx == FETCH_WIDTH && i < int'(pop_num_i) &&
				(instr_o[i].pc != step_pc || instr_o[i].instr != ~step_pc)) begin
				bad_idx   = i;
				want_pc   = step_pc;
				got_pc    = instr_o[i].pc;
				got_instr = instr_o[i].instr;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_pc_q    <= '0;
			credit_q    <= '0;
			seen_req_q  <= 1'b0;
			seen_resp_q <= 1'b0;
		end else begin
			if (redirect_i.valid) begin
				exp_pc_q <= redirect_i.pc;  // old path is gone
				credit_q <= '0;
			end else begin
				exp_pc_q <= exp_pc_q + XLEN'(pop_num_i) * XLEN'(INSTR_BYTES);
				credit_q <= credit_q + 4'(imem_req_o.valid) - 4'(iq_push_num_i != '0);
			end
			seen_req_q  <= seen_req_q | imem_req_o.valid;
			seen_resp_q <= seen_resp_q | imem_resp_i.valid;
		end
	end

	// queue stays empty until memory has answered once
	idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
		!seen_resp_q |-> instr_valid_o == '0)
	else begin
		fired[0] = 1'b1;
		$error("ERR %0t instr_valid_o got %b exp 0", $time, $sampled(instr_valid_o));
	end

	first_req_addr: assert property (@(posedge clk) disable iff (!rst_n)
		imem_req_o.valid && !seen_req_q |-> imem_req_o.addr == '0)
	else begin
		fired[1] = 1'b1;
		$error("ERR %0t imem_req_o.addr got %h exp 0", $time, $sampled(imem_req_o.addr));
	end

	popped_entries: assert property (@(posedge clk) disable iff (!rst_n)
		pop_live |-> bad_idx == FETCH_WIDTH)
	else begin
		fired[2] = 1'b1;
		$error("ERR %0t instr_o[%0d] got pc %h instr %h exp pc %h instr %h", $time,
			$sampled(bad_idx), $sampled(got_pc), $sampled(got_instr),
			$sampled(want_pc), ~$sampled(want_pc));
	end

	valid_prefix: assert property (@(posedge clk) disable iff (!rst_n)
		((instr_valid_o + FETCH_WIDTH'(1)) & instr_valid_o) == '0)
	else begin
		fired[3] = 1'b1;
		$error("ERR %0t instr_valid_o got %b exp a run of ones from bit 0", $time,
			$sampled(instr_valid_o));
	end

	flush_on_redirect: assert property (@(posedge clk) disable iff (!rst_n)
		redirect_i.valid |=> instr_valid_o == '0)
	else begin
		fired[4] = 1'b1;
		$error("ERR %0t instr_valid_o got %b exp 0 after redirect", $time,
			$sampled(instr_valid_o));
	end

	// requests in flight plus blocks waiting for the queue
	req_credit: assert property (@(posedge clk) disable iff (!rst_n)
		credit_q <= 4'(RESP_DEPTH))
	else begin
		fired[5] = 1'b1;
		$error("ERR %0t blocks outstanding got %0d exp at most %0d", $time,
			$sampled(credit_q), RESP_DEPTH);
	end

endmodule

// File: sim/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch
	import cpu_cfg_pkg::*;
	import fetch_pkg::*;
();

	localparam int unsigned RESET_CYCLES   = 10;
	localparam int unsigned TRAFFIC_CYCLES = 3000;
	localparam int unsigned DRAIN_CYCLES   = 200;
	localparam int unsigned NUM_REDIRECTS  = 6;
	localparam int unsigned MAX_CYCLES     = 4000;  // reset, traffic and drain plus margin
	localparam logic [31:0] SEED           = 32'hea04148c;

	logic                           clk;
	logic                           rst_n;
	redirect_t                      redirect;
	fetch_resp_t                    imem_resp;
	logic [CNT_W-1:0]               pop_num;
	fetch_req_t                     imem_req;
	instr_entry_t [FETCH_WIDTH-1:0] instr;
	logic [FETCH_WIDTH-1:0]         instr_valid;

	fetch_req_t  req_hold;          // request seen at the last rising edge
	int unsigned cycles = 0;
	int unsigned popped_total;
	int unsigned redir_at [NUM_REDIRECTS];

	fetch_top u_dut (
		.clk           ( clk         ),
		.rst_n         ( rst_n       ),
		.redirect_i    ( redirect    ),
		.imem_resp_i   ( imem_resp   ),
		.pop_num_i     ( pop_num     ),
		.imem_req_o    ( imem_req    ),
		.instr_o       ( instr       ),
		.instr_valid_o ( instr_valid )
	);

	bind fetch_top fetch_assertions u_checks (
		.clk           ( clk           ),
		.rst_n         ( rst_n         ),
		.redirect_i    ( redirect_i    ),
		.imem_resp_i   ( imem_resp_i   ),
		.pop_num_i     ( pop_num_i     ),
		.iq_push_num_i ( iq_push_num   ),
		.imem_req_o    ( imem_req_o    ),
		.instr_o       ( instr_o       ),
		.instr_valid_o ( instr_valid_o )
	);

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "run stopped");
	endtask

	// how many entries can be popped this cycle
	function automatic int unsigned lead_ones(input logic [FETCH_WIDTH-1:0] v);
		int unsigned n;
		n = 0;
		for (int i = 0; i < FETCH_WIDTH; i++) begin
			if (v[i] && n == i)
				n = i + 1;
		end
		return n;
	endfunction

	// memory answers the request of the previous cycle, word = ~address
	task automatic drive_memory();
		imem_resp.valid = req_hold.valid;
		for (int i = 0; i < FETCH_WIDTH; i++)
			imem_resp.data[i] = ~(req_hold.addr + XLEN'(i * INSTR_BYTES));
	endtask

	function automatic logic [XLEN-1:0] pick_pc(input int unsigned k);
		logic [XLEN-1:0] base;
		base = $urandom & 32'h000f_fff0;
		return base | XLEN'(((k + 1) % FETCH_WIDTH) * INSTR_BYTES);  // word offset 1,2,3,0,...
	endfunction

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			req_hold <= '0;
		else
			req_hold <= imem_req;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			stop_with_failure("timeout: the run did not finish within the cycle limit");
	end

	always @(negedge clk) begin
		if (u_dut.u_checks.failed)
			stop_with_failure("a bound assertion failed, see the ERR line above");
	end

	initial begin
		int unsigned nxt;
		int unsigned avail;
		bit          stall;
		bit          redir_now;

		rst_n        = 1'b0;
		redirect     = '0;
		imem_resp    = '0;
		pop_num      = '0;
		popped_total = 0;
		nxt          = 0;
		void'($urandom(SEED));
		for (int k = 0; k < NUM_REDIRECTS; k++)
			redir_at[k] = 250 + k * 450 + $urandom_range(150);

		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		for (int unsigned c = 0; c < TRAFFIC_CYCLES + DRAIN_CYCLES; c++) begin
			@(negedge clk);
			drive_memory();
			redir_now = (nxt < NUM_REDIRECTS) && (c == redir_at[nxt]);
			// no pops for 100 of every 600 cycles, fills queue and response buffer
			stall = (c < TRAFFIC_CYCLES) && ((c % 600) >= 300) && ((c % 600) < 400);
			redirect = '0;
			if (redir_now) begin
				redirect.valid = 1'b1;
				redirect.pc    = pick_pc(nxt);
				nxt++;
			end
			avail = lead_ones(instr_valid);
			if (redir_now || stall)
				pop_num = '0;
			else
				pop_num = CNT_W'($urandom_range(avail));
			popped_total += pop_num;
		end

		@(negedge clk);
		if (u_dut.u_checks.failed)
			stop_with_failure("a bound assertion failed, see the ERR line above");
		else if (nxt != NUM_REDIRECTS || popped_total < 1000)
			stop_with_failure("too few redirects or popped instructions to cover the checks");
		else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

// File: tb.f
src/cpu_cfg_pkg.sv
src/fetch_pkg.sv
src/fifo_v3.sv
src/multi_queue.sv
src/fetch_unit.sv
src/fetch_top.sv
sim/fetch_assertions.sv
sim/tb_fetch.sv

// File: Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := tb_fetch
FLIST := tb.f
LOG   := sim.log
OBJ   := obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
